// File: logic/rvPkg.sv
// RV32 ISA types and encodings shared by the fetch unit and its testbench.
// Files name members with rvPkg:: scope, no import.

package rvPkg;

  //////////////////////////////
  // basic words
  //////////////////////////////

  // byte address on the 32-bit bus
  typedef logic [31:0] addr_t;

  // one instruction word, raw or expanded
  typedef logic [31:0] instr_t;

  // compact control-flow class, carried down to M
  // a call or jump links through ra or x5
  typedef struct packed {
    logic call;
    logic ret;
    logic jumpReg;
    logic jump;
    logic branch;
  } instrClass_t;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // addi x0, x0, 0
  localparam instr_t nopInstr = 32'h0000_0013;

  // major opcodes, bits 6:0
  localparam logic [6:0] opBranch = 7'b110_0011;
  localparam logic [6:0] opJal    = 7'b110_1111;
  localparam logic [6:0] opJalr   = 7'b110_0111;
  localparam logic [6:0] opOpImm  = 7'b001_0011;
  localparam logic [6:0] opLui    = 7'b011_0111;
  localparam logic [6:0] opOp     = 7'b011_0011;
  localparam logic [6:0] opLoad   = 7'b000_0011;
  localparam logic [6:0] opStore  = 7'b010_0011;

  // link registers of the calling convention
  localparam logic [4:0] regRa      = 5'd1;
  // alternate link register
  localparam logic [4:0] regAltLink = 5'd5;

endpackage

// File: logic/fetchPkg.sv
// Pipeline control and stage payload types of the fetch unit.
// Used by the top level and the testbench with fetchPkg:: scope.

package fetchPkg;

  //////////////////////////////
  // hazard unit control
  //////////////////////////////

  // plain levels from the hazard unit, no handshake
  typedef struct packed {
    logic stallF;
    logic stallD;
    logic stallE;
    logic stallM;
    logic flushD;
    logic flushE;
    logic flushM;
  } pipeCtrl_t;

  //////////////////////////////
  // stage payloads
  //////////////////////////////

  // F to D: raw fetched word, expansion happens in D
  typedef struct packed {
    rvPkg::addr_t  pc;
    rvPkg::instr_t instr;
    // pc + 2 or pc + 4
    rvPkg::addr_t  link;
  } decodePayload_t;

  // D to E: expanded word plus its predecoded class
  typedef struct packed {
    rvPkg::addr_t       pc;
    rvPkg::instr_t      instr;
    rvPkg::addr_t       link;
    rvPkg::instrClass_t instrClass;
  } executePayload_t;

  // E to M, link no longer needed past E
  typedef struct packed {
    rvPkg::addr_t       pc;
    rvPkg::instr_t      instr;
    rvPkg::instrClass_t instrClass;
  } memPayload_t;

endpackage

// File: logic/pcGen.sv
// Fetch PC register and next-PC selection.
// Also reports a misaligned redirect target for the execute-stage fault.

module pcGen #(
  parameter rvPkg::addr_t resetVector = 32'h0000_1000,
  parameter bit           cSupported  = 1'b1
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          stallF,
  input  rvPkg::instr_t instrF,
  input  logic          pcSrcE,
  input  rvPkg::addr_t  pcTargetE,
  input  rvPkg::addr_t  privNextPcM,
  input  logic          retM,
  input  logic          trapM,
  output rvPkg::addr_t  pcF,
  output rvPkg::addr_t  pcNext,
  output rvPkg::addr_t  pcPlus,
  output logic          misaligned
);

  // fetched word is 16 bits wide
  logic         compressedF;
  // upper word address plus one, i.e. pc + 4
  logic [31:2]  pcPlusUpper;
  // selected target before alignment
  rvPkg::addr_t pcNextRaw;
  logic         privChange;

  //////////////////////////////
  // sequential successor
  //////////////////////////////

  // low bits 11 mark a full 32-bit word
  assign compressedF = cSupported && (instrF[1:0] != 2'b11);

  // one 30-bit adder serves both +2 and +4
  assign pcPlusUpper = pcF[31:2] + 30'd1;

  always_comb begin
    if (compressedF) begin
      // +2 crosses a word boundary only from the upper halfword
      if (pcF[1]) begin
        pcPlus = {pcPlusUpper, 2'b00};
      end else begin
        pcPlus = {pcF[31:2], 2'b10};
      end
    end else begin
      pcPlus = {pcPlusUpper, pcF[1:0]};
    end
  end

  //////////////////////////////
  // redirect priority
  //////////////////////////////

  assign privChange = retM | trapM;

  // privileged change beats branch, branch beats sequential
  always_comb begin
    if (privChange) begin
      pcNextRaw = privNextPcM;
    end else if (pcSrcE) begin
      pcNextRaw = pcTargetE;
    end else begin
      pcNextRaw = pcPlus;
    end
  end

  // instructions sit on halfword boundaries at least
  assign pcNext = {pcNextRaw[31:1], 1'b0};

  // checked on the raw target so an odd address is still caught
  // word alignment is required without compressed support
  assign misaligned = cSupported ? pcNextRaw[0] : |pcNextRaw[1:0];

  // fetch PC register, held while fetch is stalled
  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= resetVector;
    end else if (!stallF) begin
      pcF <= pcNext;
    end
  end

endmodule

// File: logic/decompress.sv
// Expands a subset of RVC instructions to their 32-bit form in decode.
// Unsupported 16-bit encodings become a nop and raise illegalComp.

module decompress #(
  parameter bit cSupported = 1'b1
) (
  input  rvPkg::instr_t instrRaw,
  output rvPkg::instr_t instrExp,
  output logic          illegalComp
);

  // quadrant and funct3 together pick the format
  logic [4:0]    sel;
  // full register fields of CI/CR formats
  logic [4:0]    rd;
  logic [4:0]    rs2;
  // 3-bit register fields map onto x8..x15
  logic [4:0]    rdRs2P;
  logic [4:0]    rs1P;
  // sign-extended 6-bit immediate
  logic [11:0]   immCi;
  // jump offset of c.j and c.jal
  logic [11:1]   jOff;
  // branch offset of c.beqz and c.bnez
  logic [8:1]    bOff;
  rvPkg::instr_t expC;
  logic          badC;

  assign sel    = {instrRaw[15:13], instrRaw[1:0]};
  assign rd     = instrRaw[11:7];
  assign rs2    = instrRaw[6:2];
  assign rdRs2P = {2'b01, instrRaw[4:2]};
  assign rs1P   = {2'b01, instrRaw[9:7]};
  assign immCi  = {{7{instrRaw[12]}}, instrRaw[6:2]};

  // scrambled bit order of the CJ format
  assign jOff = {instrRaw[12], instrRaw[8], instrRaw[10:9], instrRaw[6], instrRaw[7],
                 instrRaw[2], instrRaw[11], instrRaw[5:3]};

  // scrambled bit order of the CB format
  assign bOff = {instrRaw[12], instrRaw[6:5], instrRaw[2], instrRaw[11:10], instrRaw[4:3]};

  //////////////////////////////
  // expansion table
  //////////////////////////////

  always_comb begin
    expC = rvPkg::nopInstr;
    badC = 1'b0;
    case (sel)
      // c.lw
      5'b010_00: expC = {5'b0, instrRaw[5], instrRaw[12:10], instrRaw[6], 2'b00,
                         rs1P, 3'b010, rdRs2P, rvPkg::opLoad};
      // c.sw
      5'b110_00: expC = {5'b0, instrRaw[5], instrRaw[12], rdRs2P, rs1P, 3'b010,
                         instrRaw[11:10], instrRaw[6], 2'b00, rvPkg::opStore};
      // c.addi, c.nop falls out with rd and imm zero
      5'b000_01: expC = {immCi, rd, 3'b000, rd, rvPkg::opOpImm};
      // c.jal links through ra (RV32 only)
      5'b001_01: expC = {jOff[11], jOff[10:1], jOff[11], {8{jOff[11]}},
                         rvPkg::regRa, rvPkg::opJal};
      // c.li is addi from x0
      5'b010_01: expC = {immCi, 5'd0, 3'b000, rd, rvPkg::opOpImm};
      5'b011_01: begin
        // c.lui, rd x2 would be c.addi16sp which is not handled
        expC = {{14{instrRaw[12]}}, instrRaw[12], instrRaw[6:2], rd, rvPkg::opLui};
        badC = (rd == 5'd2) || ({instrRaw[12], instrRaw[6:2]} == 6'd0);
      end
      // c.j, no link
      5'b101_01: expC = {jOff[11], jOff[10:1], jOff[11], {8{jOff[11]}},
                         5'd0, rvPkg::opJal};
      // c.beqz and c.bnez, funct3 bit 13 picks bne
      5'b110_01, 5'b111_01: begin
        expC = {bOff[8], {2{bOff[8]}}, bOff[8:5], 5'd0, rs1P, {2'b00, instrRaw[13]},
                bOff[4:1], bOff[8], rvPkg::opBranch};
      end
      5'b100_10: begin
        if (!instrRaw[12]) begin
          if (rs2 == 5'd0) begin
            // c.jr, rs1 x0 is reserved
            expC = {12'd0, rd, 3'b000, 5'd0, rvPkg::opJalr};
            badC = (rd == 5'd0);
          end else begin
            // c.mv
            expC = {7'd0, rs2, 5'd0, 3'b000, rd, rvPkg::opOp};
          end
        end else begin
          if (rs2 == 5'd0) begin
            // c.jalr, rs1 x0 here is c.ebreak
            expC = {12'd0, rd, 3'b000, rvPkg::regRa, rvPkg::opJalr};
            badC = (rd == 5'd0);
          end else begin
            // c.add
            expC = {7'd0, rs2, rd, 3'b000, rd, rvPkg::opOp};
          end
        end
      end
      default: badC = 1'b1;
    endcase
  end

  // full-width words bypass the table
  always_comb begin
    if (instrRaw[1:0] == 2'b11) begin
      instrExp    = instrRaw;
      illegalComp = 1'b0;
    end else if (!cSupported || badC) begin
      instrExp    = rvPkg::nopInstr;
      illegalComp = 1'b1;
    end else begin
      instrExp    = expC;
      illegalComp = 1'b0;
    end
  end

endmodule

// File: logic/instrPredecode.sv
// Compact control-flow class of the expanded decode-stage instruction.
// Also merges the base decoder and compressed illegal flags.

module instrPredecode (
  input  rvPkg::instr_t      instrExp,
  input  logic               illegalBaseD,
  input  logic               illegalComp,
  output rvPkg::instrClass_t classD,
  output logic               illegalInstrD
);

  logic [6:0] opcode;
  // destination is a link register
  logic       rdLink;
  // source is a link register
  logic       rs1Link;
  logic       isJal;
  logic       isJalr;

  assign opcode  = instrExp[6:0];
  assign rdLink  = (instrExp[11:7] == rvPkg::regRa) || (instrExp[11:7] == rvPkg::regAltLink);
  assign rs1Link = (instrExp[19:15] == rvPkg::regRa) || (instrExp[19:15] == rvPkg::regAltLink);
  assign isJal   = (opcode == rvPkg::opJal);
  assign isJalr  = (opcode == rvPkg::opJalr);

  // jal or jalr writing ra or x5
  assign classD.call    = (isJal || isJalr) && rdLink;
  // jalr through ra or x5
  assign classD.ret     = isJalr && rs1Link;
  // any other register jump
  assign classD.jumpReg = isJalr && !rs1Link && !rdLink;
  // plain jal, no link
  assign classD.jump    = isJal && !rdLink;
  assign classD.branch  = (opcode == rvPkg::opBranch);

  // bad 32-bit or bad 16-bit encoding
  assign illegalInstrD = illegalBaseD | illegalComp;

endmodule

// File: logic/stageReg.sv
// Pipeline register with enable and synchronous clear, typed by its payload.
// Flush loads clearValue, stall holds the current contents.

module stageReg #(
  parameter type      payload_t  = logic,
  parameter payload_t clearValue = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  logic     clr,
  input  payload_t d,
  output payload_t q
);

  // clear wins over enable so a flush lands even while stalled
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      q <= clearValue;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// File: logic/ifu.sv
// Instruction fetch unit top level, F through M stages.
// Set resetVector and cSupported here, they are passed down.

module ifu #(
  parameter rvPkg::addr_t resetVector = 32'h0000_1000,
  parameter bit           cSupported  = 1'b1
) (
  input  logic                clk,
  input  logic                rst,
  input  fetchPkg::pipeCtrl_t ctrl,
  // fetch
  input  rvPkg::instr_t       instrF,
  output rvPkg::addr_t        pcF,
  // decode
  output rvPkg::addr_t        pcD,
  output rvPkg::instr_t       instrD,
  input  logic                illegalBaseD,
  output logic                illegalInstrD,
  // execute
  input  logic                pcSrcE,
  input  rvPkg::addr_t        pcTargetE,
  output rvPkg::addr_t        pcE,
  output rvPkg::instr_t       instrE,
  output rvPkg::addr_t        pcLinkE,
  output logic                predWrongE,
  // memory
  input  logic                retM,
  input  logic                trapM,
  input  rvPkg::addr_t        privNextPcM,
  output rvPkg::addr_t        pcM,
  output rvPkg::instr_t       instrM,
  output rvPkg::instrClass_t  classM,
  output logic                misalignFaultM,
  output rvPkg::addr_t        misalignAdrM
);

  // flushed stages carry a nop with no class
  localparam fetchPkg::decodePayload_t decodeClear =
    '{pc: '0, instr: rvPkg::nopInstr, link: '0};
  localparam fetchPkg::executePayload_t executeClear =
    '{pc: '0, instr: rvPkg::nopInstr, link: '0, instrClass: '0};
  localparam fetchPkg::memPayload_t memClear =
    '{pc: '0, instr: rvPkg::nopInstr, instrClass: '0};

  rvPkg::addr_t              pcNext;
  rvPkg::addr_t              pcPlus;
  logic                      misaligned;
  logic                      misalignFaultE;
  rvPkg::instrClass_t        classD;
  logic                      illegalComp;
  fetchPkg::decodePayload_t  fetchOut;
  fetchPkg::decodePayload_t  decodeIn;
  fetchPkg::executePayload_t decodeOut;
  fetchPkg::executePayload_t executeIn;
  fetchPkg::memPayload_t     executeOut;
  fetchPkg::memPayload_t     memIn;

  //////////////////////////////
  // fetch
  //////////////////////////////

  pcGen #(.resetVector(resetVector), .cSupported(cSupported)) pcUnit (
    .clk, .rst, .stallF(ctrl.stallF), .instrF, .pcSrcE, .pcTargetE, .privNextPcM,
    .retM, .trapM, .pcF, .pcNext, .pcPlus, .misaligned);

  // link address rides along from the fetch adder
  assign fetchOut = '{pc: pcF, instr: instrF, link: pcPlus};

  stageReg #(.payload_t(fetchPkg::decodePayload_t), .clearValue(decodeClear)) decodeReg (
    .clk, .rst, .en(!ctrl.stallD), .clr(ctrl.flushD), .d(fetchOut), .q(decodeIn));

  //////////////////////////////
  // decode
  //////////////////////////////

  decompress #(.cSupported(cSupported)) decompressUnit (
    .instrRaw(decodeIn.instr), .instrExp(instrD), .illegalComp);

  instrPredecode predecodeUnit (
    .instrExp(instrD), .illegalBaseD, .illegalComp, .classD, .illegalInstrD);

  assign pcD       = decodeIn.pc;
  assign decodeOut = '{pc: decodeIn.pc, instr: instrD, link: decodeIn.link, instrClass: classD};

  stageReg #(.payload_t(fetchPkg::executePayload_t), .clearValue(executeClear)) executeReg (
    .clk, .rst, .en(!ctrl.stallE), .clr(ctrl.flushE), .d(decodeOut), .q(executeIn));

  //////////////////////////////
  // execute
  //////////////////////////////

  assign pcE     = executeIn.pc;
  assign instrE  = executeIn.instr;
  assign pcLinkE = executeIn.link;

  // no predictor, so every taken redirect was mispredicted
  assign predWrongE = pcSrcE;

  // odd branch or jump target
  assign misalignFaultE = misaligned & pcSrcE;

  assign executeOut = '{pc: executeIn.pc, instr: executeIn.instr,
                        instrClass: executeIn.instrClass};

  stageReg #(.payload_t(fetchPkg::memPayload_t), .clearValue(memClear)) memReg (
    .clk, .rst, .en(!ctrl.stallM), .clr(ctrl.flushM), .d(executeOut), .q(memIn));

  // fault and its address follow stallM only
  stageReg #(.payload_t(logic), .clearValue(1'b0)) faultReg (
    .clk, .rst, .en(!ctrl.stallM), .clr(1'b0), .d(misalignFaultE), .q(misalignFaultM));

  stageReg #(.payload_t(rvPkg::addr_t), .clearValue('0)) faultAdrReg (
    .clk, .rst, .en(!ctrl.stallM), .clr(1'b0), .d(pcNext), .q(misalignAdrM));

  //////////////////////////////
  // memory
  //////////////////////////////

  assign pcM    = memIn.pc;
  assign instrM = memIn.instr;
  assign classM = memIn.instrClass;

endmodule

// File: tests/ifu_chk.sv
// Concurrent assertions on the fetch unit, bound into every ifu instance.
// The testbench reads failCount back at the end of the run.

module ifu_chk (
  input logic          clk,
  input logic          rst,
  input logic          stallF,
  input logic          flushE,
  input rvPkg::addr_t  pcF,
  input rvPkg::instr_t instrE
);
  timeunit 1ns;
  timeprecision 1ps;

  // number of failed assertions so far
  int failCount = 0;

  // fetch PC is always halfword aligned
  pcEven: assert property (@(posedge clk) disable iff (rst) pcF[0] == 1'b0)
    else begin
      failCount++;
      $error("pcF bit 0 set");
    end

  // stalled fetch holds its PC
  stallHold: assert property (@(posedge clk) disable iff (rst) stallF |=> $stable(pcF))
    else begin
      failCount++;
      $error("pcF moved during stallF");
    end

  // a flushed execute stage holds a nop
  flushNop: assert property (@(posedge clk) disable iff (rst)
                             flushE |=> instrE == rvPkg::nopInstr)
    else begin
      failCount++;
      $error("instrE not a nop after flushE");
    end

endmodule

bind ifu ifu_chk chk (
  .clk, .rst, .stallF(ctrl.stallF), .flushE(ctrl.flushE), .pcF, .instrE);

// File: tests/ifuTb.sv
// Testbench for the fetch unit, with a halfword memory model and a shadow pipeline.
// Run with tb.f; ifu_chk is bound to the DUT alongside.

module ifuTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam rvPkg::addr_t resetVector = 32'h0000_1000;
  localparam bit           cSupported  = 1'b1;
  // cycles per test that the watchdog sums
  localparam int seqCycles   = 40;
  localparam int redirCycles = 14;
  localparam int expCycles   = 30;
  localparam int ctrlCycles  = 80;
  localparam int misCycles   = 8;
  localparam int totalCycles = 4 + seqCycles + redirCycles + expCycles + ctrlCycles + misCycles;

  logic clk;
  logic rst;
  fetchPkg::pipeCtrl_t ctrl;
  rvPkg::instr_t instrF;
  logic pcSrcE, retM, trapM, illegalBaseD;
  rvPkg::addr_t pcTargetE, privNextPcM;
  rvPkg::addr_t pcF, pcD, pcE, pcLinkE, pcM, misalignAdrM;
  rvPkg::instr_t instrD, instrE, instrM;
  rvPkg::instrClass_t classM;
  logic illegalInstrD, predWrongE, misalignFaultM;

  // halfword memory as a 1 KB window that aliases above
  logic [15:0] mem [0:511];
  logic [8:0]  memIdx;
  integer seed;
  int errCount;
  int testsPassed;
  int testsFailed;
  int memPos;

  // shadow pipeline
  rvPkg::addr_t              expPcF;
  fetchPkg::decodePayload_t  shD;
  fetchPkg::executePayload_t shE;
  fetchPkg::memPayload_t     shM;
  logic                      shFault;
  rvPkg::addr_t              shFaultAdr;

  ifu #(.resetVector(resetVector), .cSupported(cSupported)) ifu_i (
    .clk, .rst, .ctrl, .instrF, .pcF, .pcD, .instrD, .illegalBaseD, .illegalInstrD,
    .pcSrcE, .pcTargetE, .pcE, .instrE, .pcLinkE, .predWrongE, .retM, .trapM,
    .privNextPcM, .pcM, .instrM, .classM, .misalignFaultM, .misalignAdrM);

  // combinational fetch at the DUT's PC
  assign memIdx = pcF[9:1];
  assign instrF = {mem[memIdx + 9'd1], mem[memIdx]};

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic rvPkg::instr_t fetchWord(input rvPkg::addr_t pc);
    logic [8:0] idx;
    idx = pc[9:1];
    return {mem[idx + 9'd1], mem[idx]};
  endfunction

  function automatic rvPkg::addr_t refLink(input rvPkg::addr_t pc, input rvPkg::instr_t w);
    return (cSupported && w[1:0] != 2'b11) ? pc + 32'd2 : pc + 32'd4;
  endfunction

  // target before bit 0 is forced low
  function automatic rvPkg::addr_t refRawNext(input rvPkg::addr_t pc, input rvPkg::instr_t w,
                                              input logic src, input rvPkg::addr_t tgt,
                                              input logic priv, input rvPkg::addr_t privPc);
    if (priv) begin
      return privPc;
    end else if (src) begin
      return tgt;
    end else begin
      return refLink(pc, w);
    end
  endfunction

  function automatic rvPkg::addr_t refNextPc(input rvPkg::addr_t raw);
    return {raw[31:1], 1'b0};
  endfunction

  // jal with a 21-bit byte offset
  function automatic rvPkg::instr_t encJal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvPkg::opJal};
  endfunction

  function automatic rvPkg::instr_t refExpand(input rvPkg::instr_t raw, output logic bad);
    logic [15:0] h;
    logic [4:0]  rd, rs2, rdP, rs1P;
    logic [6:0]  lsOff;
    logic [11:0] imm;
    logic [20:0] jOff;
    logic [12:0] bOff;
    rvPkg::instr_t r;
    h     = raw[15:0];
    rd    = h[11:7];
    rs2   = h[6:2];
    rdP   = {2'b01, h[4:2]};
    rs1P  = {2'b01, h[9:7]};
    lsOff = {h[5], h[12:10], h[6], 2'b00};
    imm   = {{6{h[12]}}, h[12], h[6:2]};
    jOff  = {{9{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    bOff  = {{4{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
    bad   = 1'b0;
    r     = rvPkg::nopInstr;
    if (raw[1:0] == 2'b11) begin
      r = raw;
    end else if (!cSupported) begin
      bad = 1'b1;
    end else begin
      case ({h[15:13], h[1:0]})
        5'b010_00: r = {5'b0, lsOff, rs1P, 3'b010, rdP, rvPkg::opLoad};
        5'b110_00: r = {5'b0, lsOff[6:5], rdP, rs1P, 3'b010, lsOff[4:0], rvPkg::opStore};
        5'b000_01: r = {imm, rd, 3'b000, rd, rvPkg::opOpImm};
        5'b001_01: r = encJal(jOff, 5'd1);
        5'b010_01: r = {imm, 5'd0, 3'b000, rd, rvPkg::opOpImm};
        5'b011_01: begin
          if (rd == 5'd2 || {h[12], h[6:2]} == 6'd0) begin
            bad = 1'b1;
          end else begin
            r = {{14{h[12]}}, h[12], h[6:2], rd, rvPkg::opLui};
          end
        end
        5'b101_01: r = encJal(jOff, 5'd0);
        5'b110_01, 5'b111_01: begin
          r = {bOff[12], bOff[10:5], 5'd0, rs1P, 2'b00, h[13], bOff[4:1], bOff[11],
               rvPkg::opBranch};
        end
        5'b100_10: begin
          if (rs2 == 5'd0) begin
            // jr or jalr through register zero is reserved
            if (rd == 5'd0) begin
              bad = 1'b1;
            end else begin
              r = {12'd0, rd, 3'b000, (h[12] ? 5'd1 : 5'd0), rvPkg::opJalr};
            end
          end else begin
            // mv adds x0, add adds rd
            r = {7'd0, rs2, (h[12] ? rd : 5'd0), 3'b000, rd, rvPkg::opOp};
          end
        end
        default: bad = 1'b1;
      endcase
    end
    if (bad) begin
      r = rvPkg::nopInstr;
    end
    return r;
  endfunction

  function automatic rvPkg::instrClass_t refClass(input rvPkg::instr_t w);
    rvPkg::instrClass_t c;
    logic rdL, rsL, jal, jalr;
    rdL       = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
    rsL       = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
    jal       = (w[6:0] == 7'b110_1111);
    jalr      = (w[6:0] == 7'b110_0111);
    c.call    = (jal || jalr) && rdL;
    c.ret     = jalr && rsL;
    c.jumpReg = jalr && !rsL && !rdL;
    c.jump    = jal && !rdL;
    c.branch  = (w[6:0] == 7'b110_0011);
    return c;
  endfunction

  // shadow pipeline advanced on the same edge as the DUT
  always @(posedge clk) begin : shadowUpdate
    rvPkg::instr_t w, e;
    rvPkg::addr_t raw;
    logic bad;
    if (rst) begin
      expPcF  <= resetVector;
      shD     <= '{pc: '0, instr: rvPkg::nopInstr, link: '0};
      shE     <= '{pc: '0, instr: rvPkg::nopInstr, link: '0, instrClass: '0};
      shM     <= '{pc: '0, instr: rvPkg::nopInstr, instrClass: '0};
      shFault <= 1'b0;
      shFaultAdr <= '0;
    end else begin
      w   = fetchWord(expPcF);
      raw = refRawNext(expPcF, w, pcSrcE, pcTargetE, retM | trapM, privNextPcM);
      e   = refExpand(shD.instr, bad);
      if (!ctrl.stallF) expPcF <= refNextPc(raw);
      if (ctrl.flushD) shD <= '{pc: '0, instr: rvPkg::nopInstr, link: '0};
      else if (!ctrl.stallD) shD <= '{pc: expPcF, instr: w, link: refLink(expPcF, w)};
      if (ctrl.flushE) shE <= '{pc: '0, instr: rvPkg::nopInstr, link: '0, instrClass: '0};
      else if (!ctrl.stallE) shE <= '{pc: shD.pc, instr: e, link: shD.link,
                                      instrClass: refClass(e)};
      if (ctrl.flushM) shM <= '{pc: '0, instr: rvPkg::nopInstr, instrClass: '0};
      else if (!ctrl.stallM) shM <= '{pc: shE.pc, instr: shE.instr, instrClass: shE.instrClass};
      if (!ctrl.stallM) begin
        shFault    <= pcSrcE & (cSupported ? raw[0] : |raw[1:0]);
        shFaultAdr <= refNextPc(raw);
      end
    end
  end

  //////////////////////////////
  // compare
  //////////////////////////////

  task automatic checkAddr(input string name, input rvPkg::addr_t exp, input rvPkg::addr_t act);
    if (exp !== act) begin
      errCount++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkInstr(input string name, input rvPkg::instr_t exp,
                            input rvPkg::instr_t act);
    if (exp !== act) begin
      errCount++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic checkClass(input string name, input rvPkg::instrClass_t exp,
                            input rvPkg::instrClass_t act);
    if (exp !== act) begin
      errCount++;
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errCount++;
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // mismatches plus failed bound assertions
  function automatic int totalErrors();
    return errCount + ifu_i.chk.failCount;
  endfunction

  // outputs are settled mid-cycle
  always @(negedge clk) begin : compare
    rvPkg::instr_t e;
    logic bad;
    if (!rst) begin
      e = refExpand(shD.instr, bad);
      checkAddr("pcF", expPcF, pcF);
      checkAddr("pcD", shD.pc, pcD);
      checkInstr("instrD", e, instrD);
      checkBit("illegalInstrD", bad | illegalBaseD, illegalInstrD);
      checkAddr("pcE", shE.pc, pcE);
      checkInstr("instrE", shE.instr, instrE);
      checkAddr("pcLinkE", shE.link, pcLinkE);
      checkBit("predWrongE", pcSrcE, predWrongE);
      checkAddr("pcM", shM.pc, pcM);
      checkInstr("instrM", shM.instr, instrM);
      checkClass("classM", shM.instrClass, classM);
      checkBit("misalignFaultM", shFault, misalignFaultM);
      checkAddr("misalignAdrM", shFaultAdr, misalignAdrM);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic putHalf(input logic [15:0] h);
    mem[memPos] = h;
    memPos++;
  endtask

  task automatic putWord(input rvPkg::instr_t w);
    putHalf(w[15:0]);
    putHalf(w[31:16]);
  endtask

  task automatic idle();
    ctrl         = '0;
    pcSrcE       = 1'b0;
    retM         = 1'b0;
    trapM        = 1'b0;
    illegalBaseD = 1'b0;
  endtask

  task automatic reportTest(input string name, input int errBefore);
    if (totalErrors() == errBefore) begin
      testsPassed++;
      $display("PASS %s", name);
    end else begin
      testsFailed++;
      $display("FAIL %s with %0d mismatches", name, totalErrors() - errBefore);
    end
  endtask

  // trap back to the start of the chosen encodings
  task automatic restart();
    trapM       = 1'b1;
    privNextPcM = resetVector;
    tick(1);
    idle();
  endtask

  initial begin : watchdog
    #(totalCycles * 12);
    $display("Timeout, the tests did not finish in %0d cycles plus margin", totalCycles);
    $display("Regression failed");
    $finish;
  end

  initial begin : main
    int e0;
    logic [31:0] r;
    seed        = 10;
    errCount    = 0;
    testsPassed = 0;
    testsFailed = 0;
    rst         = 1'b1;
    pcTargetE   = '0;
    privNextPcM = '0;
    idle();
    for (int i = 0; i < 512; i++) begin
      r      = $random(seed);
      mem[i] = r[15:0];
    end
    // compressed forms, one reserved word, then 32-bit control flow
    memPos = 0;
    putHalf(16'h0405);
    putHalf(16'h4000);
    putHalf(16'hC000);
    putHalf(16'h6405);
    putHalf(16'h8426);
    putHalf(16'h9426);
    putHalf(16'h8082);
    putHalf(16'hA001);
    putHalf(16'hC001);
    putHalf(16'h9302);
    putHalf(16'h0000);
    putWord(32'h0080_00EF);
    putWord(32'h0000_8067);
    putWord(32'h0080_006F);
    putWord(32'h0003_0067);
    putWord(32'h0003_82E7);
    putWord(32'h0020_8463);
    // return through x5
    putWord(32'h0002_8067);
    tick(4);
    rst = 1'b0;

    e0 = totalErrors();
    tick(seqCycles);
    reportTest("sequential fetch", e0);

    e0        = totalErrors();
    pcSrcE    = 1'b1;
    pcTargetE = 32'h0000_1040;
    tick(1);
    idle();
    tick(3);
    // return wins over a branch in the same cycle
    pcSrcE      = 1'b1;
    retM        = 1'b1;
    privNextPcM = 32'h0000_1080;
    tick(1);
    idle();
    tick(3);
    // so does a trap
    pcSrcE      = 1'b1;
    trapM       = 1'b1;
    privNextPcM = 32'h0000_1100;
    tick(1);
    idle();
    tick(redirCycles - 9);
    reportTest("redirect priority", e0);

    e0 = totalErrors();
    restart();
    tick(expCycles - 1);
    reportTest("expansion and class", e0);

    e0 = totalErrors();
    restart();
    for (int i = 0; i < ctrlCycles - 1; i++) begin
      r            = $random(seed);
      ctrl.stallF  = (r[2:0] == 3'd0);
      ctrl.stallD  = (r[5:3] == 3'd0);
      ctrl.stallE  = (r[8:6] == 3'd0);
      ctrl.stallM  = (r[11:9] == 3'd0);
      ctrl.flushD  = (r[14:12] == 3'd0);
      ctrl.flushE  = (r[17:15] == 3'd0);
      ctrl.flushM  = (r[20:18] == 3'd0);
      pcSrcE       = (r[23:21] == 3'd0);
      pcTargetE    = resetVector | {22'd0, r[31:23], 1'b0};
      illegalBaseD = r[24];
      tick(1);
    end
    idle();
    reportTest("pipeline control", e0);

    e0        = totalErrors();
    pcSrcE    = 1'b1;
    pcTargetE = 32'h0000_1041;
    tick(1);
    idle();
    if (misalignFaultM !== 1'b1) begin
      errCount++;
      $display("misaligned target did not raise the fault");
    end
    tick(misCycles - 1);
    reportTest("misaligned target", e0);

    $display("tests done, %0d passed, %0d failed, %0d mismatches in total", testsPassed,
             testsFailed, totalErrors());
    if (totalErrors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/rvPkg.sv
logic/fetchPkg.sv
logic/pcGen.sv
logic/decompress.sv
logic/instrPredecode.sv
logic/stageReg.sv
logic/ifu.sv
tests/ifu_chk.sv
tests/ifuTb.sv

// File: Bender.yml
package:
  name: ifu

sources:
  - logic/rvPkg.sv
  - logic/fetchPkg.sv
  - logic/pcGen.sv
  - logic/decompress.sv
  - logic/instrPredecode.sv
  - logic/stageReg.sv
  - logic/ifu.sv
  - target: test
    files:
      - tests/ifu_chk.sv
      - tests/ifuTb.sv
